//--- program.hex
// one 32-bit instruction word per line, starting at word address 0
// the last word is a beq to itself that ends the program
3C011234
34215678
2402FFFB
00221821
00612023
00612824
00A23025
0041382A
AC010008
8C080008
01074821
24000007
10220002
240A0001
114A0002
240B0111
240C0222
01496821
AC0D0010
1000FFFF

//--- cpu.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - cpu_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - cpu.sv
  - target: test
    files:
      - cpu_checker.sv
      - tb_cpu.sv

//--- tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;
	import cpu_pkg::*;

	logic        clk = 1'b0;
	logic        arst_n;
	wb_t         retire;
	store_t      store;
	logic [31:0] prog [64];
	wb_t         exp_retire [$];
	store_t      exp_store [$];
	int          retire_idx;
	int          store_idx;
	int          retire_errors;
	int          store_errors;
	int          cycles;
	int          limit;
	bit          timed_out;

	cpu i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.retire(retire),
		.store(store)
	);

	bind cpu cpu_checker i_checker (
		.clk(clk),
		.arst_n(arst_n),
		.retire(retire),
		.store(store),
		.redirect(redirect)
	);

	always #50 clk = ~clk;

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual, inout int count);
		assert (actual === expected) else begin
			$display("error: %s expected %h actual %h", name, expected, actual);
			count++;
		end
	endtask

	// sequential interpreter of the instruction subset
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] dmem [64];
		logic [31:0] pc;
		logic [31:0] instr;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] simm;
		logic [31:0] addr;
		logic [31:0] next_pc;
		logic [31:0] value;
		logic [4:0]  dest;
		logic        writes;
		bit          halt;
		wb_t         r;
		store_t      s;
		for (int i = 0; i < 32; i++) begin
			regs[i] = 32'd0;
		end
		for (int i = 0; i < 64; i++) begin
			dmem[i] = 32'd0;
		end
		pc = reset_pc;
		halt = 1'b0;
		for (int n = 0; n < 200 && !halt; n++) begin
			instr = prog[pc[7:2]];
			a = regs[instr[25:21]];
			b = regs[instr[20:16]];
			simm = {{16{instr[15]}}, instr[15:0]};
			addr = a + simm;
			next_pc = pc + 32'd4;
			dest = instr[20:16];
			value = 32'd0;
			writes = 1'b0;
			case (instr[31:26])
				op_special: begin
					dest = instr[15:11];
					writes = 1'b1;
					case (instr[5:0])
						fn_addu: value = a + b;
						fn_subu: value = a - b;
						fn_and:  value = a & b;
						fn_or:   value = a | b;
						fn_slt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: writes = 1'b0;
					endcase
				end
				op_addiu: begin
					value = addr;
					writes = 1'b1;
				end
				op_ori: begin
					value = a | {16'h0000, instr[15:0]};
					writes = 1'b1;
				end
				op_lui: begin
					value = {instr[15:0], 16'h0000};
					writes = 1'b1;
				end
				op_lw: begin
					value = dmem[addr[7:2]];
					writes = 1'b1;
				end
				op_sw: begin
					dmem[addr[7:2]] = b;
					s = '0;
					s.valid = 1'b1;
					s.addr = addr;
					s.data = b;
					exp_store.push_back(s);
				end
				op_beq: begin
					if (a == b) begin
						next_pc = pc + 32'd4 + {simm[29:0], 2'b00};
					end
					// a taken branch onto itself marks the end of the program
					halt = (next_pc == pc);
				end
				default: writes = 1'b0;
			endcase
			r = '0;
			r.valid = 1'b1;
			r.pc = pc;
			r.reg_write = writes && (dest != 5'd0);
			r.dest = dest;
			r.result = value;
			if (r.reg_write) begin
				regs[dest] = value;
			end
			exp_retire.push_back(r);
			pc = next_pc;
		end
	endtask

	task automatic check_outputs();
		wb_t    e;
		store_t es;
		if (retire.valid) begin
			if (retire_idx >= exp_retire.size()) begin
				$display("retire at pc %h came after the last expected one", retire.pc);
				retire_errors++;
			end else begin
				e = exp_retire[retire_idx];
				compare($sformatf("retire %0d pc", retire_idx), e.pc, retire.pc, retire_errors);
				compare($sformatf("retire %0d reg_write", retire_idx), e.reg_write,
					retire.reg_write, retire_errors);
				if (e.reg_write) begin
					compare($sformatf("retire %0d dest", retire_idx), e.dest, retire.dest,
						retire_errors);
					compare($sformatf("retire %0d result", retire_idx), e.result,
						retire.result, retire_errors);
				end
				retire_idx++;
			end
			assert (!(retire.reg_write && retire.dest == 5'd0)) else begin
				$display("instruction at pc %h retired a write to register 0", retire.pc);
				retire_errors++;
			end
		end
		if (store.valid) begin
			if (store_idx >= exp_store.size()) begin
				$display("store to %h was not expected by the reference model", store.addr);
				store_errors++;
			end else begin
				es = exp_store[store_idx];
				compare($sformatf("store %0d addr", store_idx), es.addr, store.addr,
					store_errors);
				compare($sformatf("store %0d data", store_idx), es.data, store.data,
					store_errors);
				store_idx++;
			end
		end
	endtask

	initial begin
		arst_n = 1'b0;
		retire_idx = 0;
		store_idx = 0;
		retire_errors = 0;
		store_errors = 0;
		cycles = 0;
		timed_out = 1'b0;
		$readmemh("program.hex", prog);
		run_model();
		limit = exp_retire.size() * 3 + 20;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		while ((retire_idx < exp_retire.size() || store_idx < exp_store.size()) && !timed_out) begin
			@(negedge clk);
			check_outputs();
			cycles++;
			if (cycles >= limit) begin
				timed_out = 1'b1;
			end
		end
		if (timed_out) begin
			$display("timeout after %0d cycles with %0d of %0d retires and %0d of %0d stores",
				cycles, retire_idx, exp_retire.size(), store_idx, exp_store.size());
		end
		$display("retire errors %0d, store errors %0d, assertion failures %0d",
			retire_errors, store_errors, i_dut.i_checker.fail_count);
		if (retire_errors == 0 && store_errors == 0 && i_dut.i_checker.fail_count == 0 &&
			!timed_out) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

//--- cpu_checker.sv
`timescale 1ns/1ps

module cpu_checker (
	input logic            clk,
	input logic            arst_n,
	input cpu_pkg::wb_t    retire,
	input cpu_pkg::store_t store,
	input logic            redirect
);
	int          fail_count = 0;
	logic [31:0] last_pc;
	logic        have_last;
	logic        branch_seen;

	// remembers the last retired pc and whether a redirect came after it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_pc <= 32'd0;
			have_last <= 1'b0;
			branch_seen <= 1'b0;
		end else if (retire.valid) begin
			last_pc <= retire.pc;
			have_last <= 1'b1;
			branch_seen <= redirect;
		end else if (redirect) begin
			branch_seen <= 1'b1;
		end
	end

	quiet_in_reset: assert property (@(posedge clk)
		(!arst_n || !$past(arst_n)) |-> !retire.valid && !store.valid)
		else begin
			fail_count++;
			$error("trace strobe high during reset or in the cycle after it");
		end

	store_aligned: assert property (@(posedge clk) disable iff (!arst_n)
		store.valid |-> store.addr[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("store address %h is not word aligned", store.addr);
		end

	// only a loop back onto the same pc may retire one pc twice in a row
	pc_moves_on: assert property (@(posedge clk) disable iff (!arst_n)
		retire.valid && have_last && !branch_seen |-> retire.pc != last_pc)
		else begin
			fail_count++;
			$error("pc %h retired twice in a row without a branch", retire.pc);
		end

endmodule

//--- cpu.sv
`timescale 1ns/1ps

module cpu #(
	parameter int imem_words = 64,
	parameter int dmem_words = 64
) (
	input  logic            clk,
	input  logic            arst_n,
	output cpu_pkg::wb_t    retire,
	output cpu_pkg::store_t store
);
	import cpu_pkg::*;

	fd_t         fd;
	de_t         de;
	em_t         em;
	logic        stall;
	logic        redirect;
	logic [31:0] redirect_pc;
	logic        ex_mem_read;
	logic [4:0]  ex_dest;

	fetch_stage #(
		.imem_words(imem_words)
	) i_fetch (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.fd(fd)
	);

	decode_stage i_decode (
		.clk(clk),
		.arst_n(arst_n),
		.fd(fd),
		.wb(retire),
		.redirect(redirect),
		.ex_mem_read(ex_mem_read),
		.ex_dest(ex_dest),
		.de(de),
		.stall(stall)
	);

	// em comes back as the M-stage forwarding source
	execute_stage i_execute (
		.clk(clk),
		.arst_n(arst_n),
		.de(de),
		.em_fwd(em),
		.wb(retire),
		.em(em),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.ex_mem_read(ex_mem_read),
		.ex_dest(ex_dest)
	);

	memory_stage #(
		.dmem_words(dmem_words)
	) i_memory (
		.clk(clk),
		.arst_n(arst_n),
		.em(em),
		.wb(retire),
		.store(store)
	);

endmodule

//--- memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
	parameter int dmem_words = 64
) (
	input  logic            clk,
	input  logic            arst_n,
	input  cpu_pkg::em_t    em,
	output cpu_pkg::wb_t    wb,
	output cpu_pkg::store_t store
);
	import cpu_pkg::*;

	localparam int addr_bits = $clog2(dmem_words);

	logic [31:0]          ram [dmem_words];
	logic [addr_bits-1:0] word_addr;
	logic                 write_en;
	logic [31:0]          load_data;

	// word addressed, the two low address bits are ignored
	assign word_addr = em.result[addr_bits+1:2];
	assign write_en = em.valid && em.mem_write;
	assign load_data = ram[word_addr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < dmem_words; i++) begin
				ram[i] <= 32'd0;
			end
		end else if (write_en) begin
			ram[word_addr] <= em.store_data;
		end
	end

	// the trace strobe shows the store in the cycle the RAM takes it
	assign store.valid = write_en;
	assign store.addr = em.result;
	assign store.data = em.store_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
		end else begin
			wb.valid <= em.valid;
			wb.pc <= em.pc;
			wb.reg_write <= em.reg_write;
			wb.dest <= em.dest;
			wb.result <= em.mem_read ? load_data : em.result;
		end
	end

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic         clk,
	input  logic         arst_n,
	input  cpu_pkg::de_t de,
	input  cpu_pkg::em_t em_fwd,
	input  cpu_pkg::wb_t wb,
	output cpu_pkg::em_t em,
	output logic         redirect,
	output logic [31:0]  redirect_pc,
	output logic         ex_mem_read,
	output logic [4:0]   ex_dest
);
	import cpu_pkg::*;

	logic [31:0] op_a;
	logic [31:0] rt_fwd;
	logic [31:0] op_b;
	logic [31:0] alu_result;

	// the younger producer wins, register 0 is never forwarded
	function automatic logic [31:0] forward(input logic [4:0] idx, input logic [31:0] val,
		input em_t m, input wb_t w);
		if (idx == 5'd0) begin
			return val;
		end
		if (m.valid && m.reg_write && m.dest == idx) begin
			return m.result;
		end
		if (w.valid && w.reg_write && w.dest == idx) begin
			return w.result;
		end
		return val;
	endfunction

	assign op_a = forward(de.rs, de.rs_val, em_fwd, wb);
	assign rt_fwd = forward(de.rt, de.rt_val, em_fwd, wb);
	assign op_b = de.use_imm ? de.imm : rt_fwd;

	always_comb begin
		case (de.alu_op)
			alu_add: alu_result = op_a + op_b;
			alu_sub: alu_result = op_a - op_b;
			alu_and: alu_result = op_a & op_b;
			alu_or:  alu_result = op_a | op_b;
			alu_slt: alu_result = ($signed(op_a) < $signed(op_b)) ? 32'd1 : 32'd0;
			alu_lui: alu_result = {op_b[15:0], 16'h0000};
			default: alu_result = 32'd0;
		endcase
	end

	// a taken beq squashes decode and fetch in the same cycle
	assign redirect = de.valid && de.branch && (op_a == rt_fwd);
	assign redirect_pc = de.pc + 32'd4 + {de.imm[29:0], 2'b00};

	assign ex_mem_read = de.valid && de.mem_read;
	assign ex_dest = de.dest;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			em <= '0;
		end else begin
			em.valid <= de.valid;
			em.pc <= de.pc;
			em.result <= alu_result;
			em.store_data <= rt_fwd;
			em.mem_read <= de.mem_read;
			em.mem_write <= de.mem_write;
			em.reg_write <= de.reg_write && !de.branch;
			em.dest <= de.dest;
		end
	end

endmodule

//--- decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input  logic         clk,
	input  logic         arst_n,
	input  cpu_pkg::fd_t fd,
	input  cpu_pkg::wb_t wb,
	input  logic         redirect,
	input  logic         ex_mem_read,
	input  logic [4:0]   ex_dest,
	output cpu_pkg::de_t de,
	output logic         stall
);
	import cpu_pkg::*;

	logic [31:0] regs [32];
	opcode_e     opcode;
	funct_e      funct;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [31:0] imm_sext;
	logic [31:0] imm_zext;
	logic [31:0] rs_val;
	logic [31:0] rt_val;
	logic        wb_write;
	logic        uses_rt;
	logic        write_en;
	de_t         de_next;

	assign opcode = opcode_e'(fd.instr[31:26]);
	assign funct = funct_e'(fd.instr[5:0]);
	assign rs = fd.instr[25:21];
	assign rt = fd.instr[20:16];
	assign rd = fd.instr[15:11];
	assign imm_sext = {{16{fd.instr[15]}}, fd.instr[15:0]};
	assign imm_zext = {16'h0000, fd.instr[15:0]};

	assign wb_write = wb.valid && wb.reg_write && (wb.dest != 5'd0);

	// write before read, so a result retiring this cycle is seen here
	assign rs_val = (rs == 5'd0) ? 32'd0 :
		(wb_write && wb.dest == rs) ? wb.result : regs[rs];
	assign rt_val = (rt == 5'd0) ? 32'd0 :
		(wb_write && wb.dest == rt) ? wb.result : regs[rt];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wb_write) begin
			regs[wb.dest] <= wb.result;
		end
	end

	always_comb begin
		de_next = '0;
		de_next.valid = fd.valid;
		de_next.pc = fd.pc;
		de_next.rs = rs;
		de_next.rt = rt;
		de_next.rs_val = rs_val;
		de_next.rt_val = rt_val;
		de_next.alu_op = alu_add;
		de_next.dest = rt;
		uses_rt = 1'b0;
		write_en = 1'b0;
		case (opcode)
			op_special: begin
				de_next.dest = rd;
				uses_rt = 1'b1;
				write_en = 1'b1;
				case (funct)
					fn_addu: de_next.alu_op = alu_add;
					fn_subu: de_next.alu_op = alu_sub;
					fn_and:  de_next.alu_op = alu_and;
					fn_or:   de_next.alu_op = alu_or;
					fn_slt:  de_next.alu_op = alu_slt;
					// unknown function codes behave as a nop
					default: write_en = 1'b0;
				endcase
			end
			op_addiu: begin
				de_next.use_imm = 1'b1;
				de_next.imm = imm_sext;
				write_en = 1'b1;
			end
			op_ori: begin
				de_next.alu_op = alu_or;
				de_next.use_imm = 1'b1;
				de_next.imm = imm_zext;
				write_en = 1'b1;
			end
			op_lui: begin
				de_next.alu_op = alu_lui;
				de_next.use_imm = 1'b1;
				de_next.imm = imm_zext;
				write_en = 1'b1;
			end
			op_lw: begin
				de_next.use_imm = 1'b1;
				de_next.imm = imm_sext;
				de_next.mem_read = 1'b1;
				write_en = 1'b1;
			end
			op_sw: begin
				de_next.use_imm = 1'b1;
				de_next.imm = imm_sext;
				de_next.mem_write = 1'b1;
				uses_rt = 1'b1;
			end
			op_beq: begin
				de_next.imm = imm_sext;
				de_next.branch = 1'b1;
				uses_rt = 1'b1;
			end
			default: begin
				write_en = 1'b0;
			end
		endcase
		// register 0 stays zero, so no write to it leaves decode
		de_next.reg_write = write_en && (de_next.dest != 5'd0);
	end

	// a load in execute cannot forward its data yet, hold the user one cycle
	assign stall = fd.valid && ex_mem_read && (ex_dest != 5'd0) &&
		((rs == ex_dest) || (uses_rt && rt == ex_dest));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			de <= '0;
		end else begin
			de <= de_next;
			if (stall || redirect) begin
				de.valid <= 1'b0;
			end
		end
	end

endmodule

//--- fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
	parameter int imem_words = 64
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         stall,
	input  logic         redirect,
	input  logic [31:0]  redirect_pc,
	output cpu_pkg::fd_t fd
);
	import cpu_pkg::*;

	localparam int addr_bits = $clog2(imem_words);

	logic [31:0] pc;
	logic [31:0] rom [imem_words];
	logic [31:0] instr;

	initial begin
		$readmemh("program.hex", rom);
	end

	// the ROM only sees the word bits of the pc, upper bits wrap
	assign instr = rom[pc[addr_bits+1:2]];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= reset_pc;
			fd <= '0;
		end else if (redirect) begin
			// the instruction being fetched is on the wrong path
			pc <= redirect_pc;
			fd.valid <= 1'b0;
		end else if (!stall) begin
			pc <= pc + 32'd4;
			fd.valid <= 1'b1;
			fd.pc <= pc;
			fd.instr <= instr;
		end
	end

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

	// primary opcodes of the supported subset
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_beq     = 6'h04,
		op_addiu   = 6'h09,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// function field of special instructions
	typedef enum logic [5:0] {
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_slt  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt,
		alu_lui
	} alu_op_e;

	localparam logic [31:0] reset_pc = 32'h0000_0000;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
	} fd_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		alu_op_e     alu_op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		logic [31:0] imm;
		logic        use_imm;
		logic        mem_read;
		logic        mem_write;
		logic        branch;
		logic        reg_write;
		logic [4:0]  dest;
	} de_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] result;
		logic [31:0] store_data;
		logic        mem_read;
		logic        mem_write;
		logic        reg_write;
		logic [4:0]  dest;
	} em_t;

	// also used as the retire trace
	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic        reg_write;
		logic [4:0]  dest;
		logic [31:0] result;
	} wb_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] addr;
		logic [31:0] data;
	} store_t;

endpackage
